// File: verification/issue_stim.txt
# Commands: W addr data | P insn | S cycles | F | E slot tag opcode rd operand1 operand2
# Values are hex except the stall count, which is decimal and starts with the next command
W 1 00000011
W 2 00000022
W 3 00000033
W 4 00000044
W 5 00000055
# Independent pair with a negative immediate
S 3
P 16120000
P 6730fffe
E 0 00 1 6 00000011 00000022
E 1 01 6 7 00000033 fffffffe
# RAW on r10 splits the pair, r10 is written before the second one issues
S 4
P 1a120000
P 2ba30000
W a 000000aa
E 0 02 1 a 00000011 00000022
E 0 03 2 b 000000aa 00000033
# A write to r0 does not split the pair
S 3
P 10120000
P 5c040000
E 0 04 1 0 00000011 00000022
E 1 05 5 c 00000000 00000044
# MUL in slot 1 waits, then pairs from slot 0
S 4
P 1d120000
P 7e340000
P 4f510000
E 0 06 1 d 00000011 00000022
E 0 07 7 e 00000033 00000044
E 1 08 4 f 00000055 00000011
# Stall right after a pair issues
S 2
P 26540000
P 67200100
P 58310000
S 3
P 6940fff0
E 0 09 2 6 00000055 00000044
E 1 0a 6 7 00000022 00000100
E 0 0b 5 8 00000033 00000011
E 1 0c 6 9 00000044 fffffff0
# Flush drops tags 0d to 0f
S 4
P 16120000
P 17120000
P 18120000
F
P 1a530000
P 7b120000
E 0 10 1 a 00000055 00000033
E 0 11 7 b 00000011 00000022
# Fill the queue while stalled, the ninth push waits for room
S 12
P 66100001
P 67200002
P 18340000
P 29510000
P 3a230000
P 4b450000
P 5c130000
P 6d50ffff
P 6e400008
E 0 12 6 6 00000011 00000001
E 1 13 6 7 00000022 00000002
E 0 14 1 8 00000033 00000044
E 1 15 2 9 00000055 00000011
E 0 16 3 a 00000022 00000033
E 1 17 4 b 00000044 00000055
E 0 18 5 c 00000011 00000033
E 1 19 6 d 00000055 ffffffff
E 0 1a 6 e 00000044 00000008

// File: decode_issue_top.f
hdl/isa_pkg.sv
hdl/issue_pkg.sv
hdl/fetch_queue.sv
hdl/insn_decoder.sv
hdl/reg_file.sv
hdl/issue_stage.sv
hdl/decode_issue_top.sv
verification/decode_issue_tb.sv

// File: Makefile
# Verilator build and run of the decode and issue testbench

VERILATOR ?= verilator
TOP       ?= decode_issue_tb
FILELIST  ?= decode_issue_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "Simulation PASSED" || (echo "Simulation FAILED"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/decode_issue_tb.sv
/* Testbench for the decode and issue stage
   Plays a command file and checks every issued slot against it */
`timescale 1ns/100ps

module decode_issue_tb import isa_pkg::*, issue_pkg::*;
;
   localparam int    QUEUE_DEPTH = 8;
   localparam int    WAIT_LIMIT  = 200;
   localparam int    DRAIN_CYCLES = 20;
   localparam string STIM_FILE   = "verification/issue_stim.txt";

   logic       clk;
   logic       rst_n;
   logic       push_valid;
   insn_t      push_insn;
   logic       queue_full;
   logic       stall;
   logic       flush;
   logic       wb_we;
   reg_addr_t  wb_addr;
   data_t      wb_data;
   slot_mask_t ex_valid;
   opcode_e    ex_opcode [NUM_SLOTS];
   tag_t       ex_tag [NUM_SLOTS];
   reg_addr_t  ex_rd [NUM_SLOTS];
   slot_mask_t ex_rd_we;
   data_t      ex_operand1 [NUM_SLOTS];
   data_t      ex_operand2 [NUM_SLOTS];

   // Issue log with one entry per valid ex slot in issue order
   slot_mask_t log_slot [$];
   opcode_e    log_opcode [$];
   tag_t       log_tag [$];
   reg_addr_t  log_rd [$];
   slot_mask_t log_rd_we [$];
   data_t      log_op1 [$];
   data_t      log_op2 [$];

   // Ex outputs as seen at the previous falling edge
   logic       last_stall;
   logic       last_flush;
   slot_mask_t held_valid;
   slot_mask_t held_rd_we;
   opcode_e    held_opcode [NUM_SLOTS];
   tag_t       held_tag [NUM_SLOTS];
   reg_addr_t  held_rd [NUM_SLOTS];
   data_t      held_op1 [NUM_SLOTS];
   data_t      held_op2 [NUM_SLOTS];

   int stall_left;
   bit full_seen;

   decode_issue_top #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) decode_issue_top_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .push_valid  (push_valid),
      .push_insn   (push_insn),
      .queue_full  (queue_full),
      .stall       (stall),
      .flush       (flush),
      .wb_we       (wb_we),
      .wb_addr     (wb_addr),
      .wb_data     (wb_data),
      .ex_valid    (ex_valid),
      .ex_opcode   (ex_opcode),
      .ex_tag      (ex_tag),
      .ex_rd       (ex_rd),
      .ex_rd_we    (ex_rd_we),
      .ex_operand1 (ex_operand1),
      .ex_operand2 (ex_operand2)
   );

   always #5 clk = ~clk;

   task automatic fail_now(input string what);
      $display("%s", what);
      $display("Test failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_opcode(input string name, input opcode_e got, input opcode_e exp);
      if (got !== exp)
         fail_now($sformatf("CHECK FAILED at %0t: %s is %s (%h), expected %s (%h)",
                            $time, name, got.name(), got, exp.name(), exp));
   endtask

   task automatic check_tag(input string name, input tag_t got, input tag_t exp);
      if (got !== exp)
         fail_now($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                            $time, name, got, exp));
   endtask

   task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
      if (got !== exp)
         fail_now($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                            $time, name, got, exp));
   endtask

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp)
         fail_now($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                            $time, name, got, exp));
   endtask

   task automatic check_mask(input string name, input slot_mask_t got, input slot_mask_t exp);
      if (got !== exp)
         fail_now($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                            $time, name, got, exp));
   endtask

   // Advance to just after the next rising edge and drop the one-cycle strobes
   task automatic next_cycle();
      @(posedge clk);
      #1;
      push_valid = 1'b0;
      wb_we      = 1'b0;
      flush      = 1'b0;
      if (stall_left > 0)
      begin
         stall      = 1'b1;
         stall_left = stall_left - 1;
      end
      else
         stall = 1'b0;
   endtask

   task automatic push_word(input insn_t insn);
      int waited;
      waited = 0;
      next_cycle();
      while (queue_full && (waited < WAIT_LIMIT))
      begin
         full_seen = 1'b1;
         next_cycle();
         waited++;
      end
      if (queue_full)
         fail_now("the fetch queue stayed full too long to push");
      else
      begin
         push_valid = 1'b1;
         push_insn  = insn;
      end
   endtask

   task automatic expect_issue(input int slot, input tag_t tag, input opcode_e op,
                               input reg_addr_t rd, input data_t op1, input data_t op2);
      int         waited;
      slot_mask_t exp_slot;
      slot_mask_t exp_rd_we;
      waited         = 0;
      exp_slot       = '0;
      exp_slot[slot] = 1'b1;
      // Every opcode but NOP writes its rd
      exp_rd_we      = (op == NOP) ? '0 : exp_slot;
      while ((log_tag.size() == 0) && (waited < WAIT_LIMIT))
      begin
         next_cycle();
         waited++;
      end
      if (log_tag.size() == 0)
         fail_now($sformatf("tag %h never issued", tag));
      else
      begin
         check_tag("issued tag", log_tag.pop_front(), tag);
         check_mask("issued slot", log_slot.pop_front(), exp_slot);
         check_opcode("issued opcode", log_opcode.pop_front(), op);
         check_reg("issued rd", log_rd.pop_front(), rd);
         check_mask("issued rd_we", log_rd_we.pop_front(), exp_rd_we);
         check_data("issued operand1", log_op1.pop_front(), op1);
         check_data("issued operand2", log_op2.pop_front(), op2);
      end
   endtask

   task automatic log_issue();
      for (int s = 0; s < NUM_SLOTS; s++)
      begin
         if (ex_valid[s])
         begin
            log_slot.push_back(slot_mask_t'(s + 1));
            log_opcode.push_back(ex_opcode[s]);
            log_tag.push_back(ex_tag[s]);
            log_rd.push_back(ex_rd[s]);
            log_rd_we.push_back(ex_rd_we & slot_mask_t'(s + 1));
            log_op1.push_back(ex_operand1[s]);
            log_op2.push_back(ex_operand2[s]);
         end
      end
   endtask

   // A stalled edge must leave every valid ex slot untouched
   task automatic check_hold();
      check_mask("ex_valid", ex_valid, held_valid);
      check_mask("ex_rd_we", ex_rd_we & held_valid, held_rd_we & held_valid);
      for (int s = 0; s < NUM_SLOTS; s++)
      begin
         if (held_valid[s])
         begin
            check_tag($sformatf("ex_tag[%0d]", s), ex_tag[s], held_tag[s]);
            check_opcode($sformatf("ex_opcode[%0d]", s), ex_opcode[s], held_opcode[s]);
            check_reg($sformatf("ex_rd[%0d]", s), ex_rd[s], held_rd[s]);
            check_data($sformatf("ex_operand1[%0d]", s), ex_operand1[s], held_op1[s]);
            check_data($sformatf("ex_operand2[%0d]", s), ex_operand2[s], held_op2[s]);
         end
      end
   endtask

   // Sample on the falling edge between the DUT edge and the next drive
   always @(negedge clk)
   begin
      if (!rst_n)
      begin
         last_stall = 1'b0;
         last_flush = 1'b0;
      end
      else
      begin
         if (last_stall && !last_flush)
            check_hold();
         else
            log_issue();
         held_valid = ex_valid;
         held_rd_we = ex_rd_we;
         for (int s = 0; s < NUM_SLOTS; s++)
         begin
            held_opcode[s] = ex_opcode[s];
            held_tag[s]    = ex_tag[s];
            held_rd[s]     = ex_rd[s];
            held_op1[s]    = ex_operand1[s];
            held_op2[s]    = ex_operand2[s];
         end
         last_stall = stall;
         last_flush = flush;
      end
   end

   initial
   begin
      int               fd;
      int               code;
      int               cycles;
      byte              cmd;
      logic [31:0]      arg0;
      logic [31:0]      arg1;
      logic [31:0]      arg2;
      logic [31:0]      arg3;
      logic [31:0]      arg4;
      logic [31:0]      arg5;
      logic [8*160-1:0] rest;

      clk        = 1'b0;
      rst_n      = 1'b0;
      push_valid = 1'b0;
      push_insn  = '0;
      stall      = 1'b0;
      flush      = 1'b0;
      wb_we      = 1'b0;
      wb_addr    = '0;
      wb_data    = '0;
      stall_left = 0;
      full_seen  = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;

      fd = $fopen(STIM_FILE, "r");
      if (fd == 0)
         fail_now("could not open the stimulus file");

      while (!$feof(fd))
      begin
         code = $fscanf(fd, " %c", cmd);
         if (code != 1)
            break;
         case (cmd)
            "#":
               code = $fgets(rest, fd);
            "W":
            begin
               code = $fscanf(fd, "%h %h", arg0, arg1);
               if (code != 2)
                  fail_now("register write line in the stimulus file is malformed");
               next_cycle();
               wb_we   = 1'b1;
               wb_addr = reg_addr_t'(arg0);
               wb_data = arg1;
            end
            "P":
            begin
               code = $fscanf(fd, "%h", arg0);
               if (code != 1)
                  fail_now("push line in the stimulus file is malformed");
               push_word(arg0);
            end
            "S":
            begin
               code = $fscanf(fd, "%d", cycles);
               if (code != 1)
                  fail_now("stall line in the stimulus file is malformed");
               stall_left = cycles;
            end
            "F":
            begin
               next_cycle();
               flush = 1'b1;
            end
            "E":
            begin
               code = $fscanf(fd, "%h %h %h %h %h %h", arg0, arg1, arg2, arg3, arg4, arg5);
               if (code != 6)
                  fail_now("expected issue line in the stimulus file is malformed");
               expect_issue(int'(arg0), tag_t'(arg1), opcode_e'(arg2[3:0]),
                            reg_addr_t'(arg3), arg4, arg5);
            end
            default:
               fail_now($sformatf("unknown command %c in the stimulus file", cmd));
         endcase
      end
      $fclose(fd);

      // Let the pipeline run dry so any stray issue shows up in the log
      for (int i = 0; i < DRAIN_CYCLES; i++)
         next_cycle();

      if (log_tag.size() != 0)
         fail_now($sformatf("%0d instructions issued that were not expected",
                            log_tag.size()));
      else if (!full_seen)
         fail_now("the fetch queue never reported full");
      else if (queue_full)
         fail_now("the fetch queue is still full after draining");
      else
      begin
         $display("Test completed successfully");
         $finish;
      end
   end

endmodule

// File: hdl/decode_issue_top.sv
/* Decode and issue top level
   Connects the fetch queue, the issue stage and the register file */
`timescale 1ns/100ps

module decode_issue_top import isa_pkg::*, issue_pkg::*;
#(
   parameter int QUEUE_DEPTH = 8
)
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       push_valid,
   input  insn_t      push_insn,
   output logic       queue_full,
   input  logic       stall,
   input  logic       flush,
   input  logic       wb_we,
   input  reg_addr_t  wb_addr,
   input  data_t      wb_data,
   output slot_mask_t ex_valid,
   output opcode_e    ex_opcode [NUM_SLOTS],
   output tag_t       ex_tag [NUM_SLOTS],
   output reg_addr_t  ex_rd [NUM_SLOTS],
   output slot_mask_t ex_rd_we,
   output data_t      ex_operand1 [NUM_SLOTS],
   output data_t      ex_operand2 [NUM_SLOTS]
);
   slot_mask_t              head_valid;
   insn_t                   head_insn [NUM_SLOTS];
   tag_t                    head_tag [NUM_SLOTS];
   pop_cnt_t                pop_cnt;
   logic [NUM_RD_PORTS-1:0] rd_en;
   reg_addr_t               rd_addr [NUM_RD_PORTS];
   data_t                   rd_data [NUM_RD_PORTS];

   fetch_queue #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) u_fetch_queue (
      .clk        (clk),
      .rst_n      (rst_n),
      .flush      (flush),
      .push_valid (push_valid),
      .push_insn  (push_insn),
      .pop_cnt    (pop_cnt),
      .queue_full (queue_full),
      .head_valid (head_valid),
      .head_insn  (head_insn),
      .head_tag   (head_tag)
   );

   issue_stage u_issue_stage (
      .clk         (clk),
      .rst_n       (rst_n),
      .stall       (stall),
      .flush       (flush),
      .head_valid  (head_valid),
      .head_insn   (head_insn),
      .head_tag    (head_tag),
      .pop_cnt     (pop_cnt),
      .rd_en       (rd_en),
      .rd_addr     (rd_addr),
      .rd_data     (rd_data),
      .ex_valid    (ex_valid),
      .ex_opcode   (ex_opcode),
      .ex_tag      (ex_tag),
      .ex_rd       (ex_rd),
      .ex_rd_we    (ex_rd_we),
      .ex_operand1 (ex_operand1),
      .ex_operand2 (ex_operand2)
   );

   reg_file u_reg_file (
      .clk     (clk),
      .rst_n   (rst_n),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .wb_we   (wb_we),
      .wb_addr (wb_addr),
      .wb_data (wb_data),
      .rd_data (rd_data)
   );

endmodule

// File: hdl/issue_stage.sv
/* Dual-slot issue stage: masks slot 1 on hazards, returns the pop count,
   reads operands and loads the execute pipeline register */
`timescale 1ns/100ps

module issue_stage import isa_pkg::*, issue_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    stall,
   input  logic                    flush,
   input  slot_mask_t              head_valid,
   input  insn_t                   head_insn [NUM_SLOTS],
   input  tag_t                    head_tag [NUM_SLOTS],
   output pop_cnt_t                pop_cnt,
   output logic [NUM_RD_PORTS-1:0] rd_en,
   output reg_addr_t               rd_addr [NUM_RD_PORTS],
   input  data_t                   rd_data [NUM_RD_PORTS],
   output slot_mask_t              ex_valid,
   output opcode_e                 ex_opcode [NUM_SLOTS],
   output tag_t                    ex_tag [NUM_SLOTS],
   output reg_addr_t               ex_rd [NUM_SLOTS],
   output slot_mask_t              ex_rd_we,
   output data_t                   ex_operand1 [NUM_SLOTS],
   output data_t                   ex_operand2 [NUM_SLOTS]
);
   logic       p_ce;
   opcode_e    dec_opcode [NUM_SLOTS];
   slot_mask_t dec_single_fu;
   slot_mask_t dec_rd_we;
   reg_addr_t  dec_rd [NUM_SLOTS];
   slot_mask_t dec_rs1_re;
   reg_addr_t  dec_rs1 [NUM_SLOTS];
   slot_mask_t dec_rs2_re;
   reg_addr_t  dec_rs2 [NUM_SLOTS];
   data_t      dec_imm [NUM_SLOTS];
   logic       raw_dep;
   slot_mask_t issue;
   slot_mask_t ex_rs1_re;
   slot_mask_t ex_rs2_re;
   data_t      ex_imm [NUM_SLOTS];

   assign p_ce = ~stall;

   for (genvar s = 0; s < NUM_SLOTS; s++)
   begin : gen_slot
      insn_decoder u_dec (
         .insn      (head_insn[s]),
         .opcode    (dec_opcode[s]),
         .single_fu (dec_single_fu[s]),
         .rd_we     (dec_rd_we[s]),
         .rd        (dec_rd[s]),
         .rs1_re    (dec_rs1_re[s]),
         .rs1       (dec_rs1[s]),
         .rs2_re    (dec_rs2_re[s]),
         .rs2       (dec_rs2[s]),
         .imm       (dec_imm[s])
      );

      // Register file answers one cycle later, in step with the ex register
      assign rd_en[2*s]     = p_ce & dec_rs1_re[s];
      assign rd_en[2*s+1]   = p_ce & dec_rs2_re[s];
      assign rd_addr[2*s]   = dec_rs1[s];
      assign rd_addr[2*s+1] = dec_rs2[s];

      assign ex_operand1[s] = ex_rs1_re[s] ? rd_data[2*s] : '0;
      assign ex_operand2[s] = ex_rs2_re[s] ? rd_data[2*s+1] : ex_imm[s];
   end

   // RAW inside the issue window, r0 never creates a dependency
   always_comb
   begin
      raw_dep = dec_rd_we[0] && (dec_rd[0] != '0) &&
                ((dec_rs1_re[1] && (dec_rs1[1] == dec_rd[0])) ||
                 (dec_rs2_re[1] && (dec_rs2[1] == dec_rd[0])));
      issue[0] = head_valid[0];
      issue[1] = head_valid[1] && issue[0] && !dec_single_fu[1] && !raw_dep;
   end

   assign pop_cnt = p_ce ? (pop_cnt_t'(issue[0]) + pop_cnt_t'(issue[1])) : '0;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         ex_valid <= '0;
      else if (flush)
         ex_valid <= '0;
      else if (p_ce)
         ex_valid <= issue;
   end

   always_ff @(posedge clk)
   begin
      if (p_ce)
      begin
         for (int s = 0; s < NUM_SLOTS; s++)
         begin
            ex_opcode[s] <= dec_opcode[s];
            ex_tag[s]    <= head_tag[s];
            ex_rd[s]     <= dec_rd[s];
            ex_imm[s]    <= dec_imm[s];
         end
         ex_rd_we  <= dec_rd_we;
         ex_rs1_re <= dec_rs1_re;
         ex_rs2_re <= dec_rs2_re;
      end
   end

   // Slot 1 only ever travels behind slot 0, with the next tag in sequence
   assert property (@(posedge clk) disable iff (!rst_n)
                    ex_valid[1] |-> ex_valid[0] && (ex_tag[1] == ex_tag[0] + tag_t'(1)))
      else $error("slot 1 reached execute without its slot 0 predecessor");

endmodule

// File: hdl/reg_file.sv
/* Architectural register file, 16 x 32 with register 0 tied to zero
   Four registered read ports and one write port with write-first bypass */
`timescale 1ns/100ps

module reg_file import isa_pkg::*, issue_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [NUM_RD_PORTS-1:0] rd_en,
   input  reg_addr_t               rd_addr [NUM_RD_PORTS],
   input  logic                    wb_we,
   input  reg_addr_t               wb_addr,
   input  data_t                   wb_data,
   output data_t                   rd_data [NUM_RD_PORTS]
);
   data_t regs [NUM_REGS];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int r = 0; r < NUM_REGS; r++)
            regs[r] <= '0;
      end
      else if (wb_we && (wb_addr != '0))
         regs[wb_addr] <= wb_data;
   end

   // Read data holds while the port is idle
   always_ff @(posedge clk)
   begin
      for (int p = 0; p < NUM_RD_PORTS; p++)
      begin
         if (rd_en[p])
         begin
            if (rd_addr[p] == '0)
               rd_data[p] <= '0;
            else if (wb_we && (wb_addr == rd_addr[p]))
               rd_data[p] <= wb_data;
            else
               rd_data[p] <= regs[rd_addr[p]];
         end
      end
   end

endmodule

// File: hdl/insn_decoder.sv
/* Instruction decoder for one issue slot
   Splits the word into opcode, register use and immediate */
`timescale 1ns/100ps

module insn_decoder import isa_pkg::*;
(
   input  insn_t     insn,
   output opcode_e   opcode,
   output logic      single_fu,
   output logic      rd_we,
   output reg_addr_t rd,
   output logic      rs1_re,
   output reg_addr_t rs1,
   output logic      rs2_re,
   output reg_addr_t rs2,
   output data_t     imm
);

   always_comb
   begin
      opcode = insn_opcode(insn);
      rd     = insn_rd(insn);
      rs1    = insn_rs1(insn);
      rs2    = insn_rs2(insn);
      imm    = sign_extend(insn_imm(insn));

      // Everything but NOP writes rd and reads rs1
      rd_we     = 1'b1;
      rs1_re    = 1'b1;
      rs2_re    = 1'b0;
      single_fu = 1'b0;

      case (opcode)
         NOP:
         begin
            rd_we  = 1'b0;
            rs1_re = 1'b0;
         end
         ADD, SUB, AND, OR, XOR:
            rs2_re = 1'b1;
         MUL:
         begin
            // Only one multiplier in the core
            rs2_re    = 1'b1;
            single_fu = 1'b1;
         end
         default:
            rs2_re = 1'b0;
      endcase
   end

endmodule

// File: hdl/fetch_queue.sv
/* Fetch queue, a circular instruction buffer that tags each word
   and presents its two oldest entries to the issue stage */
`timescale 1ns/100ps

module fetch_queue import isa_pkg::*, issue_pkg::*;
#(
   parameter int QUEUE_DEPTH = 8
)
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       flush,
   input  logic       push_valid,
   input  insn_t      push_insn,
   input  pop_cnt_t   pop_cnt,
   output logic       queue_full,
   output slot_mask_t head_valid,
   output insn_t      head_insn [NUM_SLOTS],
   output tag_t       head_tag [NUM_SLOTS]
);
   localparam int PTR_W = $clog2(QUEUE_DEPTH);
   localparam int CNT_W = PTR_W + 1;

   insn_t            insn_mem [QUEUE_DEPTH];
   tag_t             tag_mem [QUEUE_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   tag_t             next_tag;
   logic             push_ok;

   assign queue_full = (count == CNT_W'(QUEUE_DEPTH));

   // A push in a flush cycle is dropped
   assign push_ok = push_valid & ~queue_full & ~flush;

   always_ff @(posedge clk)
   begin
      if (push_ok)
      begin
         insn_mem[wr_ptr] <= push_insn;
         tag_mem[wr_ptr]  <= next_tag;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         next_tag <= '0;
      end
      else if (flush)
      begin
         // Tag counter keeps running so later words get fresh tags
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push_ok)
         begin
            wr_ptr   <= wr_ptr + PTR_W'(1);
            next_tag <= next_tag + tag_t'(1);
         end
         rd_ptr <= rd_ptr + PTR_W'(pop_cnt);
         count  <= count + CNT_W'(push_ok) - CNT_W'(pop_cnt);
      end
   end

   // Oldest entries, slot 0 first
   for (genvar s = 0; s < NUM_SLOTS; s++)
   begin : gen_head
      assign head_valid[s] = (count > CNT_W'(s));
      assign head_insn[s]  = insn_mem[rd_ptr + PTR_W'(s)];
      assign head_tag[s]   = tag_mem[rd_ptr + PTR_W'(s)];
   end

   assert property (@(posedge clk) disable iff (!rst_n) push_valid |-> !queue_full)
      else $error("push strobed while the fetch queue is full");

   assert property (@(posedge clk) disable iff (!rst_n) CNT_W'(pop_cnt) <= count)
      else $error("pop count from issue exceeds queue occupancy");

endmodule

// File: hdl/issue_pkg.sv
/* Issue window definitions
   Slot count, per-slot masks, pop count and sequence tags */
package issue_pkg;

   // Issue width of the decode stage
   localparam int NUM_SLOTS = 2;

   // Two register file reads per slot
   localparam int NUM_RD_PORTS = 2 * NUM_SLOTS;

   typedef logic [NUM_SLOTS-1:0] slot_mask_t;

   // Holds 0 to NUM_SLOTS issued instructions
   typedef logic [1:0] pop_cnt_t;

   typedef logic [7:0] tag_t;

endpackage

// File: hdl/isa_pkg.sv
/* ISA definitions for the dual-issue core
   Instruction word layout, opcodes and field decode helpers */
package isa_pkg;

   localparam int REG_AW   = 4;
   localparam int NUM_REGS = 1 << REG_AW;

   typedef logic [31:0]       insn_t;
   typedef logic [REG_AW-1:0] reg_addr_t;
   typedef logic [31:0]       data_t;
   typedef logic [15:0]       imm_t;

   typedef enum logic [3:0] {
      NOP  = 4'h0,
      ADD  = 4'h1,
      SUB  = 4'h2,
      AND  = 4'h3,
      OR   = 4'h4,
      XOR  = 4'h5,
      ADDI = 4'h6,
      MUL  = 4'h7
   } opcode_e;

   // Undefined encodings decode as NOP
   function automatic opcode_e insn_opcode(insn_t insn);
      opcode_e op;
      op = opcode_e'(insn[31:28]);
      if (insn[31:28] > MUL)
         op = NOP;
      return op;
   endfunction

   function automatic reg_addr_t insn_rd(insn_t insn);
      return insn[27:24];
   endfunction

   function automatic reg_addr_t insn_rs1(insn_t insn);
      return insn[23:20];
   endfunction

   function automatic reg_addr_t insn_rs2(insn_t insn);
      return insn[19:16];
   endfunction

   function automatic imm_t insn_imm(insn_t insn);
      return insn[15:0];
   endfunction

   function automatic data_t sign_extend(imm_t imm);
      return {{16{imm[15]}}, imm};
   endfunction

endpackage
